//--- rtl/sdmac_consts.svh
//////////////////////////////
// SDMAC constants for FIFO depth, register map,
// control bit positions and peripheral strobe length
//////////////////////////////
`ifndef SDMAC_CONSTS_SVH
`define SDMAC_CONSTS_SVH

// Longword entries in the FIFO
`define SDMAC_FIFO_DEPTH     8

// IOR/IOW high time in sclk cycles
`define SDMAC_STROBE_CYCLES  3

// Register indices
`define REG_CONTROL          3'd0
`define REG_STATUS           3'd1
`define REG_LENGTH           3'd2  // Longword count
`define REG_ADDRESS          3'd3
`define REG_FLUSH            3'd4  // Write only, reads zero

// Control register bits
`define CTRL_DMAENA          0
`define CTRL_DMADIR          1     // Set for memory to SCSI
`define CTRL_INTENA          2

`endif

//--- rtl/sdmac_pkg.sv
//////////////////////////////
// Shared SDMAC types, the request structs
// and the FIFO word union
//////////////////////////////
package sdmac_pkg;

    // CPU register port request
    typedef struct packed {
        logic        strobe;   // One cycle
        logic        write;
        logic [2:0]  addr;     // Register index
        logic [31:0] wdata;
    } regReq_t;

    // Bus master memory request
    typedef struct packed {
        logic        strobe;   // Held until ack
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
    } memReq_t;

    // Control register fields seen by both state machines
    typedef struct packed {
        logic dmaEna;
        logic dmaDir;          // 1 is memory to SCSI
        logic intEna;
    } dmaCtrl_t;

    typedef struct packed {
        logic empty;
        logic full;
        logic byteLast;        // Byte pointer on lane 3
    } fifoStatus_t;

    // One FIFO entry, whole longword or four byte lanes
    typedef union packed {
        logic [31:0]     longword;
        logic [3:0][7:0] bytes;  // Lane 0 is LSB and moves first
    } fifoWord_u;

endpackage

//--- rtl/dmaRegisters.sv
//////////////////////////////
// CPU register file with control, status, length,
// address, flush command and interrupt latch
//////////////////////////////
`timescale 1ns/100ps
`include "sdmac_consts.svh"

module dmaRegisters (
    input  logic                   sclk_i,
    input  logic                   reset_i,
    input  sdmac_pkg::regReq_t     regReq_i,
    output logic [31:0]            regRData_o,
    output logic                   regAck_o,
    input  sdmac_pkg::fifoStatus_t fifoStatus_i,
    input  logic                   xferDone_i,
    input  logic                   dmaActive_i,
    output sdmac_pkg::dmaCtrl_t    dmaCtrl_o,
    output logic [15:0]            length_o,
    output logic [31:0]            address_o,
    output logic                   start_o,
    output logic                   flush_o,
    output logic                   int_o
);
    import sdmac_pkg::*;

    dmaCtrl_t    ctrlQ;
    logic        intPending;     // Completion latch
    logic        regWrite;
    logic        wrControl;
    logic        wrStatus;
    logic        wrLength;
    logic        wrAddress;
    logic        wrFlush;
    logic [31:0] ctrlWord;
    logic [31:0] statusWord;
    logic [31:0] readMux;

    assign regWrite  = regReq_i.strobe & regReq_i.write;
    assign wrControl = regWrite && (regReq_i.addr == `REG_CONTROL);
    assign wrStatus  = regWrite && (regReq_i.addr == `REG_STATUS);   // Clears interrupt
    assign wrLength  = regWrite && (regReq_i.addr == `REG_LENGTH);
    assign wrAddress = regWrite && (regReq_i.addr == `REG_ADDRESS);
    assign wrFlush   = regWrite && (regReq_i.addr == `REG_FLUSH);

    // Control fields back at their bit positions
    always_comb begin
        ctrlWord = '0;
        ctrlWord[`CTRL_DMAENA] = ctrlQ.dmaEna;
        ctrlWord[`CTRL_DMADIR] = ctrlQ.dmaDir;
        ctrlWord[`CTRL_INTENA] = ctrlQ.intEna;
    end

    assign statusWord = {28'd0, dmaActive_i, intPending, fifoStatus_i.full, fifoStatus_i.empty};

    always_comb begin
        case (regReq_i.addr)
            `REG_CONTROL: readMux = ctrlWord;
            `REG_STATUS:  readMux = statusWord;
            `REG_LENGTH:  readMux = {16'd0, length_o};
            `REG_ADDRESS: readMux = address_o;
            default:      readMux = '0;   // Flush and spare indices
        endcase
    end

    always_ff @(posedge sclk_i) begin
        if (reset_i) begin
            ctrlQ      <= '0;
            intPending <= 1'b0;
            regAck_o   <= 1'b0;
            start_o    <= 1'b0;
            flush_o    <= 1'b0;
        end else begin
            regAck_o <= regReq_i.strobe;            // Same latency for reads and writes
            start_o  <= wrLength && (regReq_i.wdata[15:0] != 16'd0) && ctrlQ.dmaEna;
            flush_o  <= wrFlush;
            if (wrControl) begin
                ctrlQ.dmaEna <= regReq_i.wdata[`CTRL_DMAENA];
                ctrlQ.dmaDir <= regReq_i.wdata[`CTRL_DMADIR];
                ctrlQ.intEna <= regReq_i.wdata[`CTRL_INTENA];
            end
            if (xferDone_i) begin
                intPending <= 1'b1;                 // Done beats a clear in the same cycle
            end else if (wrStatus) begin
                intPending <= 1'b0;
            end
        end
    end

    // Read data and transfer setup
    always_ff @(posedge sclk_i) begin
        if (regReq_i.strobe) regRData_o <= readMux;
        if (wrLength) length_o <= regReq_i.wdata[15:0];
        if (wrAddress) address_o <= regReq_i.wdata;
    end

    assign dmaCtrl_o = ctrlQ;
    assign int_o     = intPending & ctrlQ.intEna;

endmodule

//--- rtl/dmaFifo.sv
//////////////////////////////
// Longword FIFO, byte lane packing on push
// and byte serving from the head word
//////////////////////////////
`timescale 1ns/100ps
`include "sdmac_consts.svh"

module dmaFifo (
    input  logic                   sclk_i,
    input  logic                   reset_i,
    input  logic                   flush_i,
    input  logic                   pushByte_i,
    input  logic [7:0]             byteIn_i,
    input  logic                   popByte_i,
    output logic [7:0]             byteOut_o,
    input  logic                   pushWord_i,
    input  logic [31:0]            wordIn_i,
    input  logic                   popWord_i,
    output logic [31:0]            wordOut_o,
    output sdmac_pkg::fifoStatus_t status_o
);
    import sdmac_pkg::*;

    localparam int Depth = `SDMAC_FIFO_DEPTH;
    localparam int PtrW  = $clog2(Depth);

    fifoWord_u       fifoMem [Depth];
    fifoWord_u       assembly;       // Lanes 0 to 2 of the word being packed
    fifoWord_u       headWord;
    fifoWord_u       newWord;
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [PtrW:0]   fillCount;
    logic [1:0]      bytePtr;        // Current lane
    logic            wordPush;
    logic            wordPop;

    assign headWord  = fifoMem[rdPtr];
    assign wordOut_o = headWord.longword;
    assign byteOut_o = headWord.bytes[bytePtr];   // Stable until the pop

    // A word moves when its lane 3 is pushed or consumed
    assign wordPush = pushWord_i | (pushByte_i & (bytePtr == 2'd3));
    assign wordPop  = popWord_i | (popByte_i & (bytePtr == 2'd3));

    always_comb begin
        newWord = assembly;
        newWord.bytes[3] = byteIn_i;         // Last lane goes straight in
        if (pushWord_i) begin
            newWord.longword = wordIn_i;
        end
    end

    always_ff @(posedge sclk_i) begin
        if (pushByte_i) assembly.bytes[bytePtr] <= byteIn_i;
        if (wordPush) fifoMem[wrPtr] <= newWord;
    end

    always_ff @(posedge sclk_i) begin
        if (reset_i || flush_i) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            fillCount <= '0;
            bytePtr   <= 2'd0;               // Next transfer restarts at lane 0
        end else begin
            if (wordPush) wrPtr <= wrPtr + PtrW'(1);
            if (wordPop) rdPtr <= rdPtr + PtrW'(1);
            fillCount <= fillCount + (PtrW+1)'(wordPush) - (PtrW+1)'(wordPop);
            if (pushByte_i || popByte_i) begin
                bytePtr <= bytePtr + 2'd1;   // Wraps after lane 3
            end
        end
    end

    assign status_o.empty    = (fillCount == '0);
    assign status_o.full     = (fillCount == (PtrW+1)'(Depth));
    assign status_o.byteLast = (bytePtr == 2'd3);

endmodule

//--- rtl/scsiStateMachine.sv
//////////////////////////////
// Peripheral side byte engine with DREQ/DACK
// and IOR/IOW strobes
//////////////////////////////
`timescale 1ns/100ps
`include "sdmac_consts.svh"

module scsiStateMachine (
    input  logic                   sclk_i,
    input  logic                   reset_i,
    input  sdmac_pkg::dmaCtrl_t    dmaCtrl_i,
    input  sdmac_pkg::fifoStatus_t fifoStatus_i,
    input  logic                   dreq_i,
    output logic                   dack_o,
    output logic                   ior_o,
    output logic                   iow_o,
    input  logic [7:0]             pdData_i,
    output logic [7:0]             pdData_o,
    input  logic [7:0]             byteIn_i,
    output logic [7:0]             byteOut_o,
    output logic                   pushByte_o,
    output logic                   popByte_o
);
    import sdmac_pkg::*;

    localparam int StrobeLast = `SDMAC_STROBE_CYCLES - 1;

    typedef enum logic [1:0] {
        ScsiIdle,
        ScsiStrobe,
        ScsiRecover
    } scsiState_t;

    scsiState_t state;
    logic [1:0] strobeCnt;   // Cycles into the strobe
    logic       dirQ;        // Direction of the byte in flight
    logic       byteOk;
    logic       startByte;
    logic       strobeEnd;

    // Room in the FIFO or a byte to send
    assign byteOk = dmaCtrl_i.dmaEna & dreq_i &
                    (dmaCtrl_i.dmaDir ? ~fifoStatus_i.empty : ~fifoStatus_i.full);
    assign startByte = ((state == ScsiIdle) || (state == ScsiRecover)) && byteOk;
    assign strobeEnd = (state == ScsiStrobe) && (strobeCnt == 2'(StrobeLast));

    always_ff @(posedge sclk_i) begin
        if (reset_i) begin
            state     <= ScsiIdle;
            strobeCnt <= 2'd0;
            dirQ      <= 1'b0;
        end else begin
            case (state)
                ScsiIdle, ScsiRecover: begin  // Recover is the idle cycle between bytes
                    state <= ScsiIdle;
                    if (startByte) begin
                        state     <= ScsiStrobe;
                        strobeCnt <= 2'd0;
                        dirQ      <= dmaCtrl_i.dmaDir;
                    end
                end
                ScsiStrobe: begin
                    if (strobeEnd) begin
                        state <= ScsiRecover;
                    end else begin
                        strobeCnt <= strobeCnt + 2'd1;
                    end
                end
                default: state <= ScsiIdle;
            endcase
        end
    end

    // Outgoing byte held for the whole IOW cycle
    always_ff @(posedge sclk_i) begin
        if (startByte) pdData_o <= byteIn_i;
    end

    assign dack_o = (state == ScsiStrobe);
    assign ior_o  = dack_o & ~dirQ;   // SCSI to memory
    assign iow_o  = dack_o & dirQ;

    // Device data taken on the last strobe cycle
    assign byteOut_o  = pdData_i;
    assign pushByte_o = strobeEnd & ~dirQ;
    assign popByte_o  = strobeEnd & dirQ;

endmodule

//--- rtl/busMasterStateMachine.sv
//////////////////////////////
// Bus master with request and grant,
// longword transfers, address and count
//////////////////////////////
`timescale 1ns/100ps

module busMasterStateMachine (
    input  logic                   sclk_i,
    input  logic                   reset_i,
    input  sdmac_pkg::dmaCtrl_t    dmaCtrl_i,
    input  logic                   start_i,
    input  logic [15:0]            length_i,
    input  logic [31:0]            address_i,
    input  sdmac_pkg::fifoStatus_t fifoStatus_i,
    input  logic [31:0]            wordIn_i,
    output logic [31:0]            wordOut_o,
    output logic                   pushWord_o,
    output logic                   popWord_o,
    output logic                   br_o,
    input  logic                   bg_i,
    output sdmac_pkg::memReq_t     memReq_o,
    input  logic [31:0]            memRData_i,
    input  logic                   memAck_i,
    output logic                   dmaActive_o,
    output logic                   xferDone_o
);
    import sdmac_pkg::*;

    typedef enum logic [2:0] {
        BmIdle,
        BmArb,      // Wait for grant and FIFO
        BmReq,      // Request out until ack
        BmGap,      // Request low for a cycle
        BmDrain     // Memory to SCSI tail
    } bmState_t;

    bmState_t    state;
    logic [15:0] wordCount;   // Longwords left
    logic [31:0] nextAddr;
    logic        fifoOk;
    logic        memDone;

    assign fifoOk  = dmaCtrl_i.dmaDir ? ~fifoStatus_i.full : ~fifoStatus_i.empty;
    assign memDone = (state == BmReq) && memAck_i;

    always_ff @(posedge sclk_i) begin
        if (reset_i) begin
            state      <= BmIdle;
            wordCount  <= 16'd0;
            xferDone_o <= 1'b0;
        end else begin
            xferDone_o <= 1'b0;
            if (start_i) begin
                state     <= BmArb;
                wordCount <= length_i;
            end else begin
                case (state)
                    BmArb: begin
                        if (!dmaCtrl_i.dmaEna) begin
                            state <= BmIdle;     // Abort
                        end else if (wordCount == 16'd0) begin
                            state <= dmaCtrl_i.dmaDir ? BmDrain : BmIdle;
                        end else if (bg_i && fifoOk) begin
                            state <= BmReq;
                        end
                    end
                    BmReq: begin
                        if (memAck_i) begin
                            state     <= BmGap;
                            wordCount <= wordCount - 16'd1;
                            // Final write ack ends SCSI to memory
                            xferDone_o <= !dmaCtrl_i.dmaDir && (wordCount == 16'd1);
                        end
                    end
                    BmGap: state <= BmArb;
                    BmDrain: begin
                        if (fifoStatus_i.empty) begin   // Last byte gone to the device
                            state      <= BmIdle;
                            xferDone_o <= 1'b1;
                        end else if (!dmaCtrl_i.dmaEna) begin
                            state <= BmIdle;
                        end
                    end
                    default: state <= BmIdle;
                endcase
            end
        end
    end

    // Address walks by one longword per ack
    always_ff @(posedge sclk_i) begin
        if (start_i) begin
            nextAddr <= address_i;
        end else if (memDone) begin
            nextAddr <= nextAddr + 32'd4;
        end
    end

    assign br_o = (state == BmReq) ||
                  (((state == BmArb) || (state == BmGap)) && (wordCount != 16'd0));

    always_comb begin
        memReq_o.strobe = (state == BmReq) & bg_i;    // Never without grant
        memReq_o.write  = ~dmaCtrl_i.dmaDir;
        memReq_o.addr   = nextAddr;
        memReq_o.wdata  = wordIn_i;                   // FIFO head
    end

    assign wordOut_o   = memRData_i;   // Read data in the ack cycle
    assign pushWord_o  = memDone & dmaCtrl_i.dmaDir;
    assign popWord_o   = memDone & ~dmaCtrl_i.dmaDir;
    assign dmaActive_o = (state != BmIdle);

endmodule

//--- rtl/sdmacTop.sv
//////////////////////////////
// SDMAC top with registers, FIFO
// and both state machines
//////////////////////////////
`timescale 1ns/100ps

module sdmacTop (
    input  logic               sclk_i,
    input  logic               reset_i,
    input  sdmac_pkg::regReq_t regReq_i,
    output logic [31:0]        regRData_o,
    output logic               regAck_o,
    output logic               int_o,
    output logic               br_o,
    input  logic               bg_i,
    output sdmac_pkg::memReq_t memReq_o,
    input  logic [31:0]        memRData_i,
    input  logic               memAck_i,
    input  logic               dreq_i,
    output logic               dack_o,
    output logic               ior_o,
    output logic               iow_o,
    input  logic [7:0]         pdData_i,
    output logic [7:0]         pdData_o
);
    import sdmac_pkg::*;

    dmaCtrl_t    dmaCtrl;
    fifoStatus_t fifoStatus;
    logic [15:0] length;
    logic [31:0] address;
    logic        start;
    logic        flush;
    logic        xferDone;
    logic        dmaActive;
    logic [7:0]  scsiToFifo;   // Byte from the device
    logic [7:0]  fifoToScsi;   // Head byte for the device
    logic        pushByte;
    logic        popByte;
    logic [31:0] memToFifo;
    logic [31:0] fifoToMem;
    logic        pushWord;
    logic        popWord;

    dmaRegisters u_registers (
        .sclk_i       (sclk_i),
        .reset_i      (reset_i),
        .regReq_i     (regReq_i),
        .regRData_o   (regRData_o),
        .regAck_o     (regAck_o),
        .fifoStatus_i (fifoStatus),
        .xferDone_i   (xferDone),
        .dmaActive_i  (dmaActive),
        .dmaCtrl_o    (dmaCtrl),
        .length_o     (length),
        .address_o    (address),
        .start_o      (start),
        .flush_o      (flush),
        .int_o        (int_o)
    );

    dmaFifo u_fifo (
        .sclk_i     (sclk_i),
        .reset_i    (reset_i),
        .flush_i    (flush),
        .pushByte_i (pushByte),
        .byteIn_i   (scsiToFifo),
        .popByte_i  (popByte),
        .byteOut_o  (fifoToScsi),
        .pushWord_i (pushWord),
        .wordIn_i   (memToFifo),
        .popWord_i  (popWord),
        .wordOut_o  (fifoToMem),
        .status_o   (fifoStatus)
    );

    scsiStateMachine u_scsiSm (
        .sclk_i       (sclk_i),
        .reset_i      (reset_i),
        .dmaCtrl_i    (dmaCtrl),
        .fifoStatus_i (fifoStatus),
        .dreq_i       (dreq_i),
        .dack_o       (dack_o),
        .ior_o        (ior_o),
        .iow_o        (iow_o),
        .pdData_i     (pdData_i),
        .pdData_o     (pdData_o),
        .byteIn_i     (fifoToScsi),
        .byteOut_o    (scsiToFifo),
        .pushByte_o   (pushByte),
        .popByte_o    (popByte)
    );

    busMasterStateMachine u_busSm (
        .sclk_i       (sclk_i),
        .reset_i      (reset_i),
        .dmaCtrl_i    (dmaCtrl),
        .start_i      (start),
        .length_i     (length),
        .address_i    (address),
        .fifoStatus_i (fifoStatus),
        .wordIn_i     (fifoToMem),
        .wordOut_o    (memToFifo),
        .pushWord_o   (pushWord),
        .popWord_o    (popWord),
        .br_o         (br_o),
        .bg_i         (bg_i),
        .memReq_o     (memReq_o),
        .memRData_i   (memRData_i),
        .memAck_i     (memAck_i),
        .dmaActive_o  (dmaActive),
        .xferDone_o   (xferDone)
    );

endmodule

//--- tests/sdmac_sva.sv
//////////////////////////////
// Protocol assertions for the SCSI strobes
// and the memory request, with their binds
//////////////////////////////
`timescale 1ns/100ps
`include "sdmac_consts.svh"

module sdmac_sva (
    input logic sclk_i,
    input logic reset_i,
    input logic dack_i,
    input logic ior_i,
    input logic iow_i,
    input logic reqStrobe_i,
    input logic bg_i
);
    logic [3:0] dackRun;   // High cycles of DACK so far

    always_ff @(posedge sclk_i) begin
        if (reset_i) dackRun <= 4'd0;
        else dackRun <= dack_i ? dackRun + 4'd1 : 4'd0;
    end

    strobeExclusive: assert property (@(posedge sclk_i) disable iff (reset_i)
        !(ior_i && iow_i)) else $error("ior and iow high together");

    dackWithStrobe: assert property (@(posedge sclk_i) disable iff (reset_i)
        dack_i |-> (ior_i || iow_i)) else $error("dack without ior or iow");

    reqNeedsGrant: assert property (@(posedge sclk_i) disable iff (reset_i)
        reqStrobe_i |-> bg_i) else $error("memory request without grant");

    // Never longer than the strobe length
    strobeNotLong: assert property (@(posedge sclk_i) disable iff (reset_i)
        dack_i |-> (dackRun < 4'(`SDMAC_STROBE_CYCLES))) else $error("strobe too long");

    // Never shorter either
    strobeNotShort: assert property (@(posedge sclk_i) disable iff (reset_i)
        (!dack_i && (dackRun != 4'd0)) |-> (dackRun == 4'(`SDMAC_STROBE_CYCLES)))
        else $error("strobe too short");

endmodule

bind scsiStateMachine sdmac_sva u_scsiSva (
    .sclk_i      (sclk_i),
    .reset_i     (reset_i),
    .dack_i      (dack_o),
    .ior_i       (ior_o),
    .iow_i       (iow_o),
    .reqStrobe_i (1'b0),
    .bg_i        (1'b1)
);

bind busMasterStateMachine sdmac_sva u_busSva (
    .sclk_i      (sclk_i),
    .reset_i     (reset_i),
    .dack_i      (1'b0),
    .ior_i       (1'b0),
    .iow_i       (1'b0),
    .reqStrobe_i (memReq_o.strobe),
    .bg_i        (bg_i)
);

//--- tests/sdmacTb.sv
//////////////////////////////
// SDMAC testbench with memory and SCSI device
// models, LCG stimulus and result checks
//////////////////////////////
`timescale 1ns/100ps
`include "sdmac_consts.svh"

module sdmacTb;
    import sdmac_pkg::*;

    logic        sclk_i;
    logic        reset_i;
    regReq_t     regReq;
    logic [31:0] regRData;
    logic        regAck_o;
    logic        int_o;
    logic        br_o;
    logic        bg_i;
    memReq_t     memReq_o;
    logic [31:0] memRData_i;
    logic        memAck_i;
    logic        dreq_i;
    logic        dack_o;
    logic        ior_o;
    logic        iow_o;
    logic [7:0]  pdData_i;
    logic [7:0]  pdData_o;

    logic [31:0] seed = 32'h48fc8396;
    logic [31:0] mem [logic [31:0]];   // Sparse memory
    logic [7:0]  srcBytes[$];          // Device bytes still to send
    logic [7:0]  rxBytes[$];           // Bytes the device got
    int          sinkLeft = 0;
    int          ackDelay = 0;
    logic        bpMode = 1'b0;        // Random grant, ack and dreq gaps
    logic        iorPrev = 1'b0;
    logic        iowPrev = 1'b0;

    sdmacTop i_dut (
        .sclk_i(sclk_i), .reset_i(reset_i), .regReq_i(regReq), .regRData_o(regRData),
        .regAck_o(regAck_o), .int_o(int_o), .br_o(br_o), .bg_i(bg_i),
        .memReq_o(memReq_o), .memRData_i(memRData_i), .memAck_i(memAck_i),
        .dreq_i(dreq_i), .dack_o(dack_o), .ior_o(ior_o), .iow_o(iow_o),
        .pdData_i(pdData_i), .pdData_o(pdData_o)
    );

    always #5 sclk_i = ~sclk_i;

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic failRun(input string what);
        $display("Failure at %0t: %s", $time, what);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    // Memory, arbiter and device, all driven 1 ns after the edge
    always @(posedge sclk_i) begin
        #1;
        checkValue("dack_o", 32'(dack_o), 32'(ior_o | iow_o));   // DACK rides with a strobe
        if (memAck_i) begin
            memAck_i = 1'b0;
        end else if (memReq_o.strobe) begin
            if (ackDelay == 0) begin
                if (memReq_o.write) mem[memReq_o.addr] = memReq_o.wdata;
                else if (mem.exists(memReq_o.addr)) memRData_i = mem[memReq_o.addr];
                else memRData_i = memReq_o.addr ^ 32'ha5a55a5a;   // Fill pattern
                memAck_i = 1'b1;
                ackDelay = bpMode ? int'(nextRand() % 4) : 0;
            end else begin
                ackDelay--;
            end
        end
        if (!memAck_i) bg_i = br_o && (!bpMode || (nextRand() % 4 != 0));
        if (iorPrev && !ior_o && srcBytes.size() > 0) void'(srcBytes.pop_front());
        if (iowPrev && !iow_o) begin     // Byte taken at the end of IOW
            rxBytes.push_back(pdData_o);
            sinkLeft--;
        end
        iorPrev  = ior_o;
        iowPrev  = iow_o;
        pdData_i = (srcBytes.size() > 0) ? srcBytes[0] : 8'h00;
        dreq_i   = (srcBytes.size() > 0 || sinkLeft > 0) &&
                   (!bpMode || (nextRand() % 3 != 0));
    end

    // One register cycle, ack checked one cycle after the strobe
    task automatic regAccess(input logic wr, input logic [2:0] a, input logic [31:0] d,
                             output logic [31:0] rd);
        regReq.strobe = 1'b1;
        regReq.write  = wr;
        regReq.addr   = a;
        regReq.wdata  = d;
        @(posedge sclk_i);
        #1;
        regReq.strobe = 1'b0;
        checkValue("regAck_o", 32'(regAck_o), 32'd1);
        rd = regRData;
        @(posedge sclk_i);
        #1;
        checkValue("regAck_o", 32'(regAck_o), 32'd0);
    endtask

    task automatic regWrite(input logic [2:0] a, input logic [31:0] d);
        logic [31:0] unused;
        regAccess(1'b1, a, d, unused);
    endtask

    task automatic waitDone();
        logic [31:0] st;
        logic        done;
        done = 1'b0;
        for (int i = 0; i < 4000 && !done; i++) begin
            regAccess(1'b0, `REG_STATUS, 32'd0, st);
            if (st[0] && st[1]) failRun("status shows full and empty together");
            if (st[2] && !st[3]) done = 1'b1;
        end
        if (!done) failRun("transfer did not complete in time");
    endtask

    task automatic runXfer(input logic dir, input int len, input logic [31:0] addr,
                           input logic intEna, input logic bp);
        logic [31:0] words[$];
        logic [31:0] w;
        logic [31:0] st;
        logic [7:0]  expBytes[$];
        bpMode = bp;
        rxBytes.delete();
        for (int i = 0; i < len; i++) begin
            w = nextRand();
            words.push_back(w);
            for (int b = 0; b < 4; b++) expBytes.push_back(w[8*b +: 8]);   // Lane 0 first
            if (dir) mem[addr + 32'(4 * i)] = w;
        end
        if (dir) sinkLeft = 4 * len;
        else foreach (expBytes[i]) srcBytes.push_back(expBytes[i]);
        regWrite(`REG_ADDRESS, addr);
        regWrite(`REG_CONTROL, {29'd0, intEna, dir, 1'b1});
        regWrite(`REG_LENGTH, 32'(len));
        waitDone();
        checkValue("br_o", 32'(br_o), 32'd0);   // Bus released once idle
        checkValue("int_o", 32'(int_o), 32'(intEna));
        if (dir) begin
            checkValue("rx byte count", 32'(rxBytes.size()), 32'(expBytes.size()));
            foreach (expBytes[i]) checkValue("pdData_o", 32'(rxBytes[i]), 32'(expBytes[i]));
        end else begin
            for (int i = 0; i < len; i++) begin
                checkValue("memory word", mem[addr + 32'(4 * i)], words[i]);
            end
        end
        regWrite(`REG_STATUS, 32'd0);   // Clear the interrupt
        regAccess(1'b0, `REG_STATUS, 32'd0, st);
        checkValue("intPending", 32'(st[2]), 32'd0);
        checkValue("int_o", 32'(int_o), 32'd0);
        regWrite(`REG_CONTROL, 32'd0);
        bpMode = 1'b0;
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] v;
        sclk_i     = 1'b0;
        reset_i    = 1'b1;
        regReq     = '0;
        bg_i       = 1'b0;
        memRData_i = 32'd0;
        memAck_i   = 1'b0;
        dreq_i     = 1'b0;
        pdData_i   = 8'h00;
        repeat (10) @(posedge sclk_i);
        #1;
        // Outputs quiet out of reset
        checkValue("br_o", 32'(br_o), 32'd0);
        checkValue("memReq strobe", 32'(memReq_o.strobe), 32'd0);
        checkValue("dack_o", 32'(dack_o), 32'd0);
        checkValue("ior_o", 32'(ior_o), 32'd0);
        checkValue("iow_o", 32'(iow_o), 32'd0);
        checkValue("int_o", 32'(int_o), 32'd0);
        checkValue("regAck_o", 32'(regAck_o), 32'd0);
        reset_i = 1'b0;
        @(posedge sclk_i);
        #1;

        // Register read back, DMA left disabled
        regWrite(`REG_CONTROL, 32'd6);
        regAccess(1'b0, `REG_CONTROL, 32'd0, rd);
        checkValue("control", rd, 32'd6);
        v = nextRand() >> 16;
        regWrite(`REG_LENGTH, v);
        regAccess(1'b0, `REG_LENGTH, 32'd0, rd);
        checkValue("length", rd, v);
        v = nextRand();
        regWrite(`REG_ADDRESS, v);
        regAccess(1'b0, `REG_ADDRESS, 32'd0, rd);
        checkValue("address", rd, v);
        regWrite(`REG_CONTROL, 32'd0);

        // A word and a half in the FIFO, then flush
        for (int i = 0; i < 6; i++) srcBytes.push_back(8'(nextRand()));
        regWrite(`REG_CONTROL, 32'd1);
        for (int i = 0; i < 200 && srcBytes.size() > 0; i++) @(posedge sclk_i);
        if (srcBytes.size() > 0) failRun("device bytes were not taken before the flush");
        repeat (3) @(posedge sclk_i);
        #1;
        regAccess(1'b0, `REG_STATUS, 32'd0, rd);
        checkValue("status empty", 32'(rd[0]), 32'd0);   // One whole word held
        regWrite(`REG_FLUSH, 32'd1);
        regAccess(1'b0, `REG_STATUS, 32'd0, rd);
        checkValue("status empty", 32'(rd[0]), 32'd1);
        regWrite(`REG_CONTROL, 32'd0);

        for (int k = 0; k < 8; k++) begin
            runXfer(k[0], 1 + int'(nextRand() % 6), nextRand() & 32'hfffff000,
                    (k != 3) && (k != 6), k >= 2);
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

//--- project.f
+incdir+rtl
rtl/sdmac_pkg.sv
rtl/dmaRegisters.sv
rtl/dmaFifo.sv
rtl/scsiStateMachine.sv
rtl/busMasterStateMachine.sv
rtl/sdmacTop.sv
tests/sdmac_sva.sv
tests/sdmacTb.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the SDMAC testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module sdmacTb \
    -Mdir obj_dir -o sdmacSim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sdmacSim > sim.log 2>&1

grep -q "^TEST PASS$" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
